//--- design/bicubic_pkg.sv
`default_nettype none

package bicubic_pkg;

    // one 8-bit grayscale sample
    typedef logic [7:0] pixel_t;

    // four pixels of one window row, index 0 is the oldest pixel
    typedef pixel_t [3:0] win_row_t;

    // 4x4 neighbourhood, row 0 is the oldest line
    typedef struct packed {
        win_row_t [3:0] row;
    } window_t;

    // per-row result of the horizontal pass
    typedef struct packed {
        // column-1 pixel, passed through for the vertical pass
        pixel_t             center;
        // -1/9/9/-1 sum over columns 0..3, still scaled by 16
        logic signed [13:0] half;
    } row_sum_t;

    // the four output samples in emission order
    typedef struct packed {
        pixel_t integ;
        pixel_t horiz;
        pixel_t vert;
        pixel_t diag;
    } quad_t;

    // half-phase bicubic taps, they sum to 16
    localparam int TAP_OUTER = -1;
    localparam int TAP_INNER = 9;

    // one pass divides by 16, two passes by 256
    localparam int ROUND_1D = 8;
    localparam int SHIFT_1D = 4;
    localparam int ROUND_2D = 128;
    localparam int SHIFT_2D = 8;

    // four-tap kernel, outer taps on a and d
    function automatic int tap_sum(input int a, input int b, input int c, input int d);
        return TAP_OUTER * (a + d) + TAP_INNER * (b + c);
    endfunction

endpackage

`default_nettype wire

//--- design/line_delay.sv
`timescale 1ns/1ps
`default_nettype none

module line_delay import bicubic_pkg::*; #(
    parameter int DEPTH = 6
) (
    input  wire    clk,
    input  wire    arst_n,
    input  logic   shift_en,
    input  pixel_t din,
    output pixel_t dout
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // circular storage, one slot per pixel of a line
    pixel_t             mem [DEPTH];
    logic   [PTR_W-1:0] ptr;

    // same slot is read before it is overwritten
    // so the output is the pixel from DEPTH shifts ago
    assign dout = mem[ptr];

    always_ff @(posedge clk) begin
        if (shift_en) begin
            mem[ptr] <= din;
        end
    end

    // pointer wraps at the end of the line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (shift_en) begin
            if (ptr == PTR_W'(DEPTH - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module window_buffer import bicubic_pkg::*; #(
    parameter int IMG_WIDTH  = 6,
    parameter int IMG_HEIGHT = 5
) (
    input  wire     clk,
    input  wire     arst_n,
    input  logic    in_valid,
    input  pixel_t  in_pix,
    output logic    in_ready,
    output logic    win_valid,
    output window_t win,
    input  logic    win_ready
);

    localparam int COL_W = (IMG_WIDTH > 4) ? $clog2(IMG_WIDTH) : 2;
    localparam int ROW_W = (IMG_HEIGHT > 4) ? $clog2(IMG_HEIGHT) : 2;

    logic             accept;
    logic             col_last;
    logic             row_last;
    logic             win_done;
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;

    // value entering the right end of each window row
    pixel_t row_in [4];

    window_t win_q;

    // stall only while a full window waits for the filter
    assign in_ready = !win_valid || win_ready;
    assign accept   = in_valid && in_ready;

    // bottom row takes the new pixel directly
    assign row_in[3] = in_pix;

    // each line delay is fed by the input of the row below
    // and feeds the row above, one line later
    for (genvar i = 0; i < 3; i++) begin : g_line
        line_delay #(
            .DEPTH (IMG_WIDTH)
        ) u_line_delay (
            .clk      (clk),
            .arst_n   (arst_n),
            .shift_en (accept),
            .din      (row_in[i+1]),
            .dout     (row_in[i])
        );
    end

    // window shifts left by one column per accepted pixel
    // no reset, contents only matter once win_valid is set
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 3; c++) begin
                    win_q.row[r][c] <= win_q.row[r][c+1];
                end
                win_q.row[r][3] <= row_in[r];
            end
        end
    end

    assign win = win_q;

    // position of the pixel being accepted
    assign col_last = (col_cnt == COL_W'(IMG_WIDTH - 1));
    assign row_last = (row_cnt == ROW_W'(IMG_HEIGHT - 1));

    // full window once three earlier rows and columns exist
    assign win_done = (col_cnt >= COL_W'(3)) && (row_cnt >= ROW_W'(3));

    // raster counters, frames follow back to back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (accept) begin
            if (col_last) begin
                col_cnt <= '0;
                row_cnt <= row_last ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // output slot is empty or being taken whenever a pixel is accepted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            win_valid <= 1'b0;
        end else if (accept) begin
            win_valid <= win_done;
        end else if (win_ready) begin
            win_valid <= 1'b0;
        end
    end

    // a held window must not move until the filter takes it
    a_win_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        win_valid && !win_ready |=> win_valid && $stable(win)
    );

endmodule

`default_nettype wire

//--- design/horiz_filter.sv
`timescale 1ns/1ps
`default_nettype none

module horiz_filter import bicubic_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  logic           win_valid,
    input  window_t        win,
    output logic           win_ready,
    output logic           rows_valid,
    output row_sum_t [3:0] rows,
    input  logic           rows_ready
);

    logic           load;
    row_sum_t [3:0] rows_d;

    // one-entry stage, refill while the current entry leaves
    assign win_ready = !rows_valid || rows_ready;
    assign load      = win_valid && win_ready;

    // per row, keep the centre pixel and the unscaled half-phase sum
    // rounding waits for vert_filter so the diagonal is rounded once
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rows_d[r].center = win.row[r][1];
            rows_d[r].half   = 14'(tap_sum(int'(win.row[r][0]),
                                           int'(win.row[r][1]),
                                           int'(win.row[r][2]),
                                           int'(win.row[r][3])));
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (load) begin
            rows <= rows_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rows_valid <= 1'b0;
        end else if (load) begin
            rows_valid <= 1'b1;
        end else if (rows_ready) begin
            rows_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/vert_filter.sv
`timescale 1ns/1ps
`default_nettype none

module vert_filter import bicubic_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  logic           rows_valid,
    input  row_sum_t [3:0] rows,
    output logic           rows_ready,
    output logic           quad_valid,
    output quad_t          quad,
    input  logic           quad_ready
);

    logic  load;
    int    h_val;
    int    v_val;
    int    d_val;
    quad_t quad_d;

    // saturate to the 8-bit pixel range
    function automatic pixel_t clamp_pix(input int v);
        if (v < 0) begin
            return 8'd0;
        end
        if (v > 255) begin
            return 8'd255;
        end
        return pixel_t'(v);
    endfunction

    assign rows_ready = !quad_valid || quad_ready;
    assign load       = rows_valid && rows_ready;

    always_comb begin
        // horizontal, row 1 only, one pass so divide by 16
        h_val = (int'(rows[1].half) + ROUND_1D) >>> SHIFT_1D;

        // vertical, taps down the centre column
        v_val = (tap_sum(int'(rows[0].center), int'(rows[1].center),
                         int'(rows[2].center), int'(rows[3].center))
                 + ROUND_1D) >>> SHIFT_1D;

        // diagonal, taps down the half sums, two passes so divide by 256
        d_val = (tap_sum(int'(rows[0].half), int'(rows[1].half),
                         int'(rows[2].half), int'(rows[3].half))
                 + ROUND_2D) >>> SHIFT_2D;

        // integer phase is the source pixel itself
        quad_d.integ = rows[1].center;
        quad_d.horiz = clamp_pix(h_val);
        quad_d.vert  = clamp_pix(v_val);
        quad_d.diag  = clamp_pix(d_val);
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quad <= quad_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            quad_valid <= 1'b0;
        end else if (load) begin
            quad_valid <= 1'b1;
        end else if (quad_ready) begin
            quad_valid <= 1'b0;
        end
    end

    // an X here means stale line-delay data reached a valid window
    a_quad_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        quad_valid |-> !$isunknown(quad)
    );

endmodule

`default_nettype wire

//--- design/sample_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_serializer import bicubic_pkg::*; (
    input  wire    clk,
    input  wire    arst_n,
    input  logic   quad_valid,
    input  quad_t  quad,
    output logic   quad_ready,
    output logic   out_valid,
    output pixel_t out_pix,
    input  logic   out_ready
);

    logic       load;
    logic       take;
    logic       last;
    logic [1:0] phase;
    quad_t      quad_q;

    assign take = out_valid && out_ready;
    assign last = (phase == 2'd3);

    // next quad loads on the edge that takes the diagonal, no bubble
    assign quad_ready = !out_valid || (out_ready && last);
    assign load       = quad_valid && quad_ready;

    always_ff @(posedge clk) begin
        if (load) begin
            quad_q <= quad;
        end
    end

    // phase order integer, horizontal, vertical, diagonal
    always_comb begin
        case (phase)
            2'd0:    out_pix = quad_q.integ;
            2'd1:    out_pix = quad_q.horiz;
            2'd2:    out_pix = quad_q.vert;
            default: out_pix = quad_q.diag;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            phase     <= 2'd0;
        end else if (load) begin
            out_valid <= 1'b1;
            phase     <= 2'd0;
        end else if (take) begin
            // drained after the fourth sample
            if (last) begin
                out_valid <= 1'b0;
            end
            phase <= phase + 2'd1;
        end
    end

    a_out_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_pix)
    );

endmodule

`default_nettype wire

//--- design/bicubic_upscaler.sv
`timescale 1ns/1ps
`default_nettype none

module bicubic_upscaler import bicubic_pkg::*; #(
    parameter int IMG_WIDTH  = 6,
    parameter int IMG_HEIGHT = 5
) (
    input  wire    clk,
    input  wire    arst_n,
    input  logic   in_valid,
    input  pixel_t in_pix,
    output logic   in_ready,
    output logic   out_valid,
    output pixel_t out_pix,
    input  logic   out_ready
);

    // window buffer to horizontal pass
    logic           win_valid;
    logic           win_ready;
    window_t        win;

    // horizontal to vertical pass
    logic           rows_valid;
    logic           rows_ready;
    row_sum_t [3:0] rows;

    // vertical pass to serializer
    logic           quad_valid;
    logic           quad_ready;
    quad_t          quad;

    window_buffer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_window_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .in_ready  (in_ready),
        .win_valid (win_valid),
        .win       (win),
        .win_ready (win_ready)
    );

    horiz_filter u_horiz_filter (
        .clk        (clk),
        .arst_n     (arst_n),
        .win_valid  (win_valid),
        .win        (win),
        .win_ready  (win_ready),
        .rows_valid (rows_valid),
        .rows       (rows),
        .rows_ready (rows_ready)
    );

    vert_filter u_vert_filter (
        .clk        (clk),
        .arst_n     (arst_n),
        .rows_valid (rows_valid),
        .rows       (rows),
        .rows_ready (rows_ready),
        .quad_valid (quad_valid),
        .quad       (quad),
        .quad_ready (quad_ready)
    );

    sample_serializer u_sample_serializer (
        .clk        (clk),
        .arst_n     (arst_n),
        .quad_valid (quad_valid),
        .quad       (quad),
        .quad_ready (quad_ready),
        .out_valid  (out_valid),
        .out_pix    (out_pix),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

//--- verification/tb_bicubic_upscaler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bicubic_upscaler import bicubic_pkg::*; ();

    localparam int    IMG_WIDTH  = 6;
    localparam int    IMG_HEIGHT = 5;
    localparam int    FRAME_PIX  = IMG_WIDTH * IMG_HEIGHT;
    // (6-3) x (5-3) windows, four samples each
    localparam int    FRAME_OUT  = 4 * (IMG_WIDTH - 3) * (IMG_HEIGHT - 3);
    localparam int    MAX_WAIT   = 1000;
    // idle window after the last frame, longer than the pipeline depth
    localparam int    DRAIN_CYCLES = 32;
    localparam string STIM_FILE  = "verification/bicubic_stim.txt";

    logic   clk;
    logic   arst_n;
    logic   in_valid;
    pixel_t in_pix;
    logic   in_ready;
    logic   out_valid;
    pixel_t out_pix;
    logic   out_ready;

    integer seed;
    int     errors;
    int     tests_failed;
    bit     timeout_hit;

    // per test, filled from the stim file
    string  test_name [$];
    bit     gaps_q    [$];
    bit     stalls_q  [$];
    pixel_t frame_pix [$];
    pixel_t exp_pix   [$];

    bicubic_upscaler #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_bicubic_upscaler (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_pix    (in_pix),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pix   (out_pix),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_pix(input string name, input int idx,
                             input pixel_t expected, input pixel_t actual);
        if (actual !== expected) begin
            $display("Fail %s sample %0d: expected %0d, actual %0d",
                     name, idx, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail %s: expected %0d samples in the frame, received %0d",
                     name, expected, actual);
            errors++;
        end
    endtask

    // block layout: test line, 5 pixel rows, 6 expected quads
    task automatic load_stim();
        int    fd;
        int    code;
        int    part;
        int    i;
        int    gaps_f;
        int    stall_f;
        int    v [6];
        string line;
        string word;
        string name;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            errors++;
            return;
        end
        part = 0;
        while ($fgets(line, fd) > 0) begin
            // blank and comment lines
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            if (part == 0) begin
                code = $sscanf(line, "%s %s %d %d", word, name, gaps_f, stall_f);
                if (code != 4 || word != "test") begin
                    $display("malformed test line in stimulus file: %s", line);
                    errors++;
                end
                test_name.push_back(name);
                gaps_q.push_back(gaps_f != 0);
                stalls_q.push_back(stall_f != 0);
            end else if (part <= IMG_HEIGHT) begin
                code = $sscanf(line, "%d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
                if (code != IMG_WIDTH) begin
                    $display("malformed pixel row in stimulus file: %s", line);
                    errors++;
                end
                for (i = 0; i < IMG_WIDTH; i++) begin
                    frame_pix.push_back(pixel_t'(v[i]));
                end
            end else begin
                code = $sscanf(line, "%d %d %d %d", v[0], v[1], v[2], v[3]);
                if (code != 4) begin
                    $display("malformed expected line in stimulus file: %s", line);
                    errors++;
                end
                for (i = 0; i < 4; i++) begin
                    exp_pix.push_back(pixel_t'(v[i]));
                end
            end
            part = (part == IMG_HEIGHT + FRAME_OUT / 4) ? 0 : part + 1;
        end
        $fclose(fd);
        if (part != 0 || test_name.size() == 0) begin
            $display("stimulus file is empty or ends inside a test block");
            errors++;
        end
    endtask

    // one frame in raster order, optional idle cycles before each pixel
    task automatic drive_frame(input int t);
        int i;
        int gap;
        int waited;
        bit accepted;
        for (i = 0; i < FRAME_PIX; i++) begin
            if (timeout_hit) begin
                return;
            end
            @(negedge clk);
            gap = gaps_q[t] ? ($random(seed) & 3) : 0;
            while (gap > 0) begin
                in_valid = 1'b0;
                @(negedge clk);
                gap--;
            end
            in_valid = 1'b1;
            in_pix   = frame_pix[t * FRAME_PIX + i];
            // pixel is taken on the first rising edge with in_ready high
            waited   = 0;
            accepted = 1'b0;
            while (!accepted && waited < MAX_WAIT) begin
                @(posedge clk);
                accepted = in_ready;
                waited++;
            end
            if (!accepted) begin
                $display("timeout: DUT did not accept pixel %0d of test %s", i, test_name[t]);
                timeout_hit = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic collect_frame(input int t);
        int     k;
        int     got;
        int     waited;
        int     err_start;
        bit     taken;
        pixel_t sample;
        err_start = errors;
        got       = 0;
        for (k = 0; k < FRAME_OUT; k++) begin
            waited = 0;
            taken  = 1'b0;
            while (!taken && waited < MAX_WAIT && !timeout_hit) begin
                @(negedge clk);
                out_ready = stalls_q[t] ? ($random(seed) % 2 != 0) : 1'b1;
                @(posedge clk);
                if (out_valid && out_ready) begin
                    taken  = 1'b1;
                    sample = out_pix;
                end
                waited++;
            end
            if (!taken) begin
                if (!timeout_hit) begin
                    $display("timeout: no output sample %0d for test %s", k, test_name[t]);
                    timeout_hit = 1'b1;
                    errors++;
                end
                break;
            end
            got++;
            check_pix(test_name[t], k, exp_pix[t * FRAME_OUT + k], sample);
        end
        // input has ended, any further sample is a duplicate
        if (t == test_name.size() - 1 && !timeout_hit) begin
            for (k = 0; k < DRAIN_CYCLES; k++) begin
                @(negedge clk);
                out_ready = 1'b1;
                @(posedge clk);
                if (out_valid && out_ready) begin
                    got++;
                end
            end
        end
        check_count(test_name[t], FRAME_OUT, got);
        if (errors == err_start) begin
            $display("test %s: ok, %0d samples", test_name[t], got);
        end else begin
            $display("test %s: %0d errors", test_name[t], errors - err_start);
            tests_failed++;
        end
    endtask

    initial begin
        seed         = 32'hef49_7d22;
        errors       = 0;
        tests_failed = 0;
        timeout_hit  = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        in_pix       = '0;
        out_ready    = 1'b0;
        load_stim();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        // frames stream back to back while the sink checks them in order
        fork
            begin
                for (int t = 0; t < test_name.size(); t++) begin
                    drive_frame(t);
                end
                @(negedge clk);
                in_valid = 1'b0;
            end
            begin
                for (int t = 0; t < test_name.size(); t++) begin
                    collect_frame(t);
                end
            end
        join
        $display("%0d tests, %0d failed, %0d errors", test_name.size(), tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/bicubic_stim.txt
# each block: test <name> <in_valid gaps 0/1> <out_ready stalls 0/1> then 5 rows of 6 pixels
# then one line per window in raster order: integer horizontal vertical diagonal (decimal)
test flat 0 0
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100
100 100 100 100
100 100 100 100
100 100 100 100
100 100 100 100
100 100 100 100
test ramp_texture 0 0
12 40 64 90 110 140
30 52 80 70 120 150
48 96 60 100 130 170
20 70 110 84 160 180
36 88 92 140 150 200
52 68 76 73
80 74 68 73
70 93 85 103
96 79 85 88
60 76 85 84
100 115 90 117
test clamp 0 0
0 255 255 0 0 255
255 0 0 255 255 0
255 0 0 255 255 0
0 255 255 0 0 255
0 255 255 0 0 255
0 0 0 0
0 128 0 128
255 255 255 255
0 0 128 128
0 128 128 128
255 255 128 128
test stall_texture 1 1
12 40 64 90 110 140
30 52 80 70 120 150
48 96 60 100 130 170
20 70 110 84 160 180
36 88 92 140 150 200
52 68 76 73
80 74 68 73
70 93 85 103
96 79 85 88
60 76 85 84
100 115 90 117
test gaps_clamp 1 0
0 255 255 0 0 255
255 0 0 255 255 0
255 0 0 255 255 0
0 255 255 0 0 255
0 255 255 0 0 255
0 0 0 0
0 128 0 128
255 255 255 255
0 0 128 128
0 128 128 128
255 255 128 128

//--- src.f
design/bicubic_pkg.sv
design/line_delay.sv
design/window_buffer.sv
design/horiz_filter.sv
design/vert_filter.sv
design/sample_serializer.sv
design/bicubic_upscaler.sv
verification/tb_bicubic_upscaler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run from the project root, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_bicubic_upscaler \
        -o tb_bicubic_upscaler \
    && ./obj_dir/tb_bicubic_upscaler 2>&1 | tee "$LOG" \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "Done: errors found" "$LOG" && { echo "simulation reported errors"; exit 1; }
grep -q "Done: no errors" "$LOG" || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
